// File: rtl/uart_dbg_pkg.sv
////////////////////////////////////////////////////////////
// UART debug server shared definitions
// Protocol byte codes, header field sizes, data types and
// the command engine state encoding
////////////////////////////////////////////////////////////

package uart_dbg_pkg;

  typedef logic [7:0]  dbg_byte_t;
  typedef logic [31:0] dbg_addr_t;
  typedef logic [15:0] dbg_len_t;

  // Opcodes sent by the host
  typedef enum logic [7:0] {
    CMD_ACK   = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12
  } dbg_cmd_e;

  // Reply bytes
  localparam dbg_byte_t RSP_ACK = 8'h06;
  localparam dbg_byte_t RSP_EOT = 8'h04;

  // Header field sizes in bytes, LSB first on the line
  localparam int unsigned ADDR_BYTES = 4;
  localparam int unsigned LEN_BYTES  = 2;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_SEND_ACK,
    ST_RD_BUS,
    ST_RD_SEND,
    ST_WR_DATA,
    ST_WR_BUS,
    ST_SEND_EOT
  } dbg_state_e;

endpackage

// File: rtl/uart_rx.sv
////////////////////////////////////////////////////////////
// UART byte receiver
// 8N1 framing, samples each bit at its middle and pulses
// rx_valid_o for one cycle per good frame
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_rx import uart_dbg_pkg::*; #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      rx_i,
  output dbg_byte_t rx_data_o,
  output logic      rx_valid_o
);

  localparam int unsigned CntW = $clog2(ClksPerBit);

  logic            rx_meta_q, rx_sync_q, rx_prev_q;
  logic            active_q;
  logic [CntW-1:0] clk_cnt_q;
  logic [3:0]      bit_cnt_q;
  logic            valid_q;
  dbg_byte_t       shift_q;
  logic            start_edge;
  logic            sample;

  assign start_edge = rx_prev_q & ~rx_sync_q;
  assign sample     = active_q && (clk_cnt_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      active_q  <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      valid_q   <= 1'b0;
      if (!active_q) begin
        if (start_edge) begin
          // First sample lands in the middle of the start bit
          active_q  <= 1'b1;
          clk_cnt_q <= CntW'(ClksPerBit / 2 - 1);
          bit_cnt_q <= '0;
        end
      end else if (clk_cnt_q != '0) begin
        clk_cnt_q <= clk_cnt_q - 1'b1;
      end else begin
        clk_cnt_q <= CntW'(ClksPerBit - 1);
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (bit_cnt_q == 4'd0 && rx_sync_q) begin
          // Glitch, not a real start bit
          active_q <= 1'b0;
        end else if (bit_cnt_q == 4'd9) begin
          active_q <= 1'b0;
          valid_q  <= rx_sync_q;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_cnt_q >= 4'd1 && bit_cnt_q <= 4'd8) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_data_o  = shift_q;
  assign rx_valid_o = valid_q;

endmodule

// File: rtl/uart_tx.sv
////////////////////////////////////////////////////////////
// UART byte transmitter
// Sends one 8N1 frame per start request, line idles high
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_tx import uart_dbg_pkg::*; #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  dbg_byte_t tx_data_i,
  input  logic      tx_start_i,
  output logic      tx_busy_o,
  output logic      tx_o
);

  localparam int unsigned CntW = $clog2(ClksPerBit);

  logic [9:0]      shift_q;
  logic            busy_q;
  logic [CntW-1:0] clk_cnt_q;
  logic [3:0]      bit_cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      shift_q   <= '1;
      busy_q    <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        // Stop, data LSB first, start bit at the bottom
        shift_q   <= {1'b1, tx_data_i, 1'b0};
        busy_q    <= 1'b1;
        clk_cnt_q <= CntW'(ClksPerBit - 1);
        bit_cnt_q <= '0;
      end
    end else if (clk_cnt_q != '0) begin
      clk_cnt_q <= clk_cnt_q - 1'b1;
    end else if (bit_cnt_q == 4'd9) begin
      // Stop bit done, line is already high
      busy_q <= 1'b0;
    end else begin
      shift_q   <= {1'b1, shift_q[9:1]};
      clk_cnt_q <= CntW'(ClksPerBit - 1);
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  assign tx_o      = shift_q[0];
  assign tx_busy_o = busy_q;

endmodule

// File: rtl/uart_dbg_ctrl.sv
////////////////////////////////////////////////////////////
// Debug command engine
// Parses ACK, read and write commands from the UART, sends
// replies and moves bytes over Wishbone classic
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_dbg_ctrl import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  dbg_byte_t rx_data_i,
  input  logic      rx_valid_i,
  output dbg_byte_t tx_data_o,
  output logic      tx_start_o,
  input  logic      tx_busy_i,
  output logic      wb_cyc_o,
  output logic      wb_stb_o,
  output logic      wb_we_o,
  output dbg_addr_t wb_adr_o,
  output dbg_byte_t wb_dat_o,
  input  dbg_byte_t wb_dat_i,
  input  logic      wb_ack_i
);

  dbg_state_e state_q, state_d;
  dbg_cmd_e   cmd_q, cmd_d;
  logic [1:0] cnt_q, cnt_d;
  logic       tx_start_q, tx_start_d;
  logic       cyc_q, cyc_d;
  logic       we_q, we_d;
  dbg_addr_t  addr_q, addr_d;
  dbg_len_t   len_q, len_d;
  dbg_byte_t  tx_data_q, tx_data_d;
  dbg_byte_t  wdat_q, wdat_d;
  logic       tx_ready;
  logic       last_byte;

  // Busy rises one cycle after the start pulse, so mask that gap
  assign tx_ready  = !tx_busy_i && !tx_start_q;
  assign last_byte = (len_q == dbg_len_t'(1));

  always_comb begin
    state_d    = state_q;
    cmd_d      = cmd_q;
    cnt_d      = cnt_q;
    tx_start_d = 1'b0;
    cyc_d      = cyc_q;
    we_d       = we_q;
    addr_d     = addr_q;
    len_d      = len_q;
    tx_data_d  = tx_data_q;
    wdat_d     = wdat_q;
    unique case (state_q)
      ST_IDLE: begin
        if (rx_valid_i) begin
          case (rx_data_i)
            CMD_ACK: begin
              cmd_d   = CMD_ACK;
              state_d = ST_SEND_ACK;
            end
            CMD_READ, CMD_WRITE: begin
              cmd_d   = dbg_cmd_e'(rx_data_i);
              cnt_d   = '0;
              state_d = ST_ADDR;
            end
            default: ;
          endcase
        end
      end
      ST_ADDR: begin
        if (rx_valid_i) begin
          addr_d = {rx_data_i, addr_q[31:8]};
          cnt_d  = cnt_q + 1'b1;
          if (cnt_q == 2'(ADDR_BYTES - 1)) begin
            cnt_d   = '0;
            state_d = ST_LEN;
          end
        end
      end
      ST_LEN: begin
        if (rx_valid_i) begin
          len_d = {rx_data_i, len_q[15:8]};
          cnt_d = cnt_q + 1'b1;
          if (cnt_q == 2'(LEN_BYTES - 1)) begin
            state_d = ST_SEND_ACK;
          end
        end
      end
      ST_SEND_ACK: begin
        if (tx_ready) begin
          tx_data_d  = RSP_ACK;
          tx_start_d = 1'b1;
          if (cmd_q == CMD_ACK) begin
            state_d = ST_IDLE;
          end else if (len_q == '0) begin
            state_d = ST_SEND_EOT;
          end else if (cmd_q == CMD_READ) begin
            state_d = ST_RD_BUS;
          end else begin
            state_d = ST_WR_DATA;
          end
        end
      end
      ST_RD_BUS: begin
        // Fetch only once the previous byte has left
        if (!cyc_q) begin
          if (tx_ready) begin
            cyc_d = 1'b1;
            we_d  = 1'b0;
          end
        end else if (wb_ack_i) begin
          cyc_d     = 1'b0;
          tx_data_d = wb_dat_i;
          state_d   = ST_RD_SEND;
        end
      end
      ST_RD_SEND: begin
        if (tx_ready) begin
          tx_start_d = 1'b1;
          addr_d     = addr_q + dbg_addr_t'(1);
          len_d      = len_q - dbg_len_t'(1);
          state_d    = last_byte ? ST_SEND_EOT : ST_RD_BUS;
        end
      end
      ST_WR_DATA: begin
        if (rx_valid_i) begin
          wdat_d  = rx_data_i;
          cyc_d   = 1'b1;
          we_d    = 1'b1;
          state_d = ST_WR_BUS;
        end
      end
      ST_WR_BUS: begin
        if (wb_ack_i) begin
          cyc_d   = 1'b0;
          we_d    = 1'b0;
          addr_d  = addr_q + dbg_addr_t'(1);
          len_d   = len_q - dbg_len_t'(1);
          state_d = last_byte ? ST_SEND_EOT : ST_WR_DATA;
        end
      end
      ST_SEND_EOT: begin
        if (tx_ready) begin
          tx_data_d  = RSP_EOT;
          tx_start_d = 1'b1;
          state_d    = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      cmd_q      <= CMD_ACK;
      cnt_q      <= '0;
      tx_start_q <= 1'b0;
      cyc_q      <= 1'b0;
      we_q       <= 1'b0;
    end else begin
      state_q    <= state_d;
      cmd_q      <= cmd_d;
      cnt_q      <= cnt_d;
      tx_start_q <= tx_start_d;
      cyc_q      <= cyc_d;
      we_q       <= we_d;
    end
  end

  // Header fields and data bytes
  always_ff @(posedge clk) begin
    addr_q    <= addr_d;
    len_q     <= len_d;
    tx_data_q <= tx_data_d;
    wdat_q    <= wdat_d;
  end

  assign tx_data_o  = tx_data_q;
  assign tx_start_o = tx_start_q;
  assign wb_cyc_o   = cyc_q;
  assign wb_stb_o   = cyc_q;
  assign wb_we_o    = we_q;
  assign wb_adr_o   = addr_q;
  assign wb_dat_o   = wdat_q;

endmodule

// File: rtl/dbg_mem.sv
////////////////////////////////////////////////////////////
// Byte-wide Wishbone classic slave memory
// One access per strobe, ack in the following cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dbg_mem import uart_dbg_pkg::*; #(
  parameter int unsigned MemAddrW = 8
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  dbg_addr_t wb_adr_i,
  input  dbg_byte_t wb_dat_i,
  output dbg_byte_t wb_dat_o,
  output logic      wb_ack_o
);

  dbg_byte_t           mem_q [2**MemAddrW];
  dbg_byte_t           rdata_q;
  logic                ack_q;
  logic                req;
  logic [MemAddrW-1:0] idx;

  // Held strobe after ack is not a new request
  assign req = wb_cyc_i && wb_stb_i && !ack_q;
  // Upper address bits ignored, memory wraps
  assign idx = wb_adr_i[MemAddrW-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      if (wb_we_i) begin
        mem_q[idx] <= wb_dat_i;
      end
      rdata_q <= mem_q[idx];
    end
  end

  assign wb_dat_o = rdata_q;
  assign wb_ack_o = ack_q;

endmodule

// File: rtl/uart_dbg_top.sv
////////////////////////////////////////////////////////////
// UART debug server top level
// Receiver, transmitter, command engine and byte memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_dbg_top import uart_dbg_pkg::*; #(
  parameter int unsigned ClksPerBit = 16,
  parameter int unsigned MemAddrW   = 8
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  dbg_byte_t rx_data;
  logic      rx_valid;
  dbg_byte_t tx_data;
  logic      tx_start;
  logic      tx_busy;

  // Wishbone between engine and memory
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  dbg_addr_t wb_adr;
  dbg_byte_t wb_dat_w;
  dbg_byte_t wb_dat_r;
  logic      wb_ack;

  uart_rx #(
    .ClksPerBit ( ClksPerBit )
  ) u_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_data_o  ( rx_data   ),
    .rx_valid_o ( rx_valid  )
  );

  uart_tx #(
    .ClksPerBit ( ClksPerBit )
  ) u_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_start_i ( tx_start  ),
    .tx_busy_o  ( tx_busy   ),
    .tx_o       ( uart_tx_o )
  );

  uart_dbg_ctrl u_ctrl (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .rx_data_i  ( rx_data  ),
    .rx_valid_i ( rx_valid ),
    .tx_data_o  ( tx_data  ),
    .tx_start_o ( tx_start ),
    .tx_busy_i  ( tx_busy  ),
    .wb_cyc_o   ( wb_cyc   ),
    .wb_stb_o   ( wb_stb   ),
    .wb_we_o    ( wb_we    ),
    .wb_adr_o   ( wb_adr   ),
    .wb_dat_o   ( wb_dat_w ),
    .wb_dat_i   ( wb_dat_r ),
    .wb_ack_i   ( wb_ack   )
  );

  dbg_mem #(
    .MemAddrW ( MemAddrW )
  ) u_mem (
    .clk      ( clk      ),
    .rst_n_i  ( rst_n_i  ),
    .wb_cyc_i ( wb_cyc   ),
    .wb_stb_i ( wb_stb   ),
    .wb_we_i  ( wb_we    ),
    .wb_adr_i ( wb_adr   ),
    .wb_dat_i ( wb_dat_w ),
    .wb_dat_o ( wb_dat_r ),
    .wb_ack_o ( wb_ack   )
  );

endmodule

// File: dv/uart_dbg_sva.sv
////////////////////////////////////////////////////////////
// UART debug server assertions
// Wishbone request rules and UART idle level around reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_dbg_sva import uart_dbg_pkg::*; (
  input logic       clk,
  input logic       rst_n_i,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_ack,
  input dbg_addr_t  wb_adr,
  input logic       uart_tx_o,
  input dbg_state_e state
);

  // Strobe only inside a cycle, and only from a bus state
  assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_stb |-> wb_cyc && (state inside {ST_RD_BUS, ST_WR_BUS}))
    else $error("wb_stb high without wb_cyc or outside a bus state");

  // Request held with a stable address until the slave acks
  assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else $error("wb_stb dropped or wb_adr changed before wb_ack");

  // Line idles high during reset and right after release
  assert property (@(posedge clk) !rst_n_i |=> uart_tx_o)
    else $error("uart_tx_o not high around reset");

endmodule

bind uart_dbg_top uart_dbg_sva u_sva (
  .clk       ( clk            ),
  .rst_n_i   ( rst_n_i        ),
  .wb_cyc    ( wb_cyc         ),
  .wb_stb    ( wb_stb         ),
  .wb_ack    ( wb_ack         ),
  .wb_adr    ( wb_adr         ),
  .uart_tx_o ( uart_tx_o      ),
  .state     ( u_ctrl.state_q )
);

// File: dv/uart_dbg_tb.sv
////////////////////////////////////////////////////////////
// UART debug server testbench
// Acts as the UART host, runs a table of commands and checks
// every reply frame against a reference memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_dbg_tb import uart_dbg_pkg::*; ();

  localparam int CLKS       = 16;
  localparam int CLK_PERIOD = 20;
  localparam int FRAME_CLKS = 10 * CLKS;
  localparam int NUM_ROWS   = 11;

  logic clk;
  logic rst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;

  // Row layout {opcode, address, length, data mix}
  logic [63:0] stim_tbl [NUM_ROWS] = '{
    {CMD_ACK,   32'h0000_0000, 16'd0, 8'h00},
    {CMD_WRITE, 32'h0000_0010, 16'd8, 8'h5a},
    {CMD_READ,  32'h0000_0010, 16'd8, 8'h00},
    {CMD_WRITE, 32'h0000_0040, 16'd0, 8'h00},
    {CMD_READ,  32'h0000_0040, 16'd0, 8'h00},
    {8'ha5,     32'h0000_0000, 16'd0, 8'h00},
    {CMD_ACK,   32'h0000_0000, 16'd0, 8'h00},
    {CMD_WRITE, 32'h0000_00fc, 16'd8, 8'h3c},
    {CMD_READ,  32'h0000_00fc, 16'd8, 8'h00},
    {CMD_READ,  32'h0000_01fc, 16'd8, 8'h00},
    {CMD_READ,  32'habcd_0000, 16'd4, 8'h00}
  };

  dbg_byte_t ref_mem [256];
  dbg_byte_t host_q [$];
  dbg_byte_t exp_q [$];
  dbg_byte_t rsp_q [$];
  int        frame_cnt = 0;
  integer    seed = 32;

  uart_dbg_top #(
    .ClksPerBit ( CLKS ),
    .MemAddrW   ( 8    )
  ) u_dut (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Each start bit opens one frame, skip to its stop bit
  always begin
    @(negedge uart_tx_o);
    if (rst_n_i === 1'b1) begin
      frame_cnt++;
    end
    repeat (FRAME_CLKS - CLKS / 2) @(posedge clk);
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error: %0t ns %s expected %0h actual %0h", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic send_byte(input dbg_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (CLKS - 1) @(posedge clk);
    end
  endtask

  // Sampled on the falling clock edge, away from line updates
  task automatic recv_byte(output dbg_byte_t b);
    logic [9:0] frame;
    @(negedge uart_tx_o);
    repeat (CLKS / 2) @(negedge clk);
    for (int i = 0; i < 10; i++) begin
      frame[i] = uart_tx_o;
      if (i < 9) repeat (CLKS) @(negedge clk);
    end
    check_val("uart_tx_o start bit", 32'd0, frame[0]);
    check_val("uart_tx_o stop bit", 32'd1, frame[9]);
    b = frame[8:1];
  endtask

  task automatic send_all();
    foreach (host_q[k]) send_byte(host_q[k]);
  endtask

  task automatic collect_replies(input int n);
    dbg_byte_t b;
    for (int k = 0; k < n; k++) begin
      recv_byte(b);
      rsp_q.push_back(b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    dbg_byte_t op;
    dbg_addr_t addr;
    dbg_len_t  len;
    dbg_byte_t mix;
    dbg_byte_t b;
    int        frames_exp;
    frames_exp = 0;
    uart_rx_i <= 1'b1;
    rst_n_i   <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    repeat (5) @(posedge clk);

    for (int r = 0; r < NUM_ROWS; r++) begin
      {op, addr, len, mix} = stim_tbl[r];
      host_q.delete();
      exp_q.delete();
      rsp_q.delete();
      host_q.push_back(op);
      if (op == CMD_ACK) begin
        exp_q.push_back(RSP_ACK);
      end else if (op == CMD_READ || op == CMD_WRITE) begin
        for (int i = 0; i < ADDR_BYTES; i++) host_q.push_back(addr[8*i +: 8]);
        for (int i = 0; i < LEN_BYTES; i++) host_q.push_back(len[8*i +: 8]);
        exp_q.push_back(RSP_ACK);
        for (int i = 0; i < len; i++) begin
          if (op == CMD_WRITE) begin
            b = dbg_byte_t'($random(seed)) ^ mix;
            host_q.push_back(b);
            ref_mem[(addr + 32'(i)) % 256] = b;
          end else begin
            exp_q.push_back(ref_mem[(addr + 32'(i)) % 256]);
          end
        end
        exp_q.push_back(RSP_EOT);
      end

      fork
        send_all();
        collect_replies(exp_q.size());
      join

      foreach (exp_q[k]) begin
        check_val($sformatf("uart_tx_o row %0d reply %0d", r, k), exp_q[k], rsp_q[k]);
      end

      // Quiet line afterwards, no extra frames
      repeat (2 * FRAME_CLKS) @(posedge clk);
      frames_exp += exp_q.size();
      check_val("uart_tx_o frame count", frames_exp, frame_cnt);
    end

    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    int unsigned limit_frames;
    limit_frames = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit_frames += stim_tbl[r][23:8] + 14;
    end
    #((limit_frames * FRAME_CLKS + 200) * CLK_PERIOD);
    $display("timeout: the command table did not complete in the expected time");
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: compile.f
rtl/uart_dbg_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_dbg_ctrl.sv
rtl/dbg_mem.sv
rtl/uart_dbg_top.sv
dv/uart_dbg_sva.sv
dv/uart_dbg_tb.sv
